//--- bench/sss_detector_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "nr_sync_config.svh"

module sss_detector_props import nr_cell_pkg::*; (
    input logic    clk_i,
    input logic    reset_ni,
    input logic    req_i,
    input logic    ack_i,
    input logic    s_ready_i,
    input logic    n_id_valid_i,
    input n_id_1_t n_id_1_i
);

    // number of assertion failures so far
    int fail_count = 0;

    // correlator only answers a pending request
    ack_after_req: assert property (@(posedge clk_i) disable iff (!reset_ni)
        $rose(ack_i) |-> $past(req_i))
        else begin
            $error("ack rose without a pending req");
            fail_count++;
        end

    req_held: assert property (@(posedge clk_i) disable iff (!reset_ni)
        req_i && !ack_i |=> req_i)
        else begin
            $error("req dropped before ack was seen");
            fail_count++;
        end

    valid_single: assert property (@(posedge clk_i) disable iff (!reset_ni)
        n_id_valid_i |=> !n_id_valid_i)
        else begin
            $error("n_id_valid_o lasted more than one cycle");
            fail_count++;
        end

    id1_in_range: assert property (@(posedge clk_i) disable iff (!reset_ni)
        n_id_1_i <= n_id_1_t'(`N_ID_1_MAX))
        else begin
            $error("n_id_1_o above the highest group identity");
            fail_count++;
        end

    // no new bits while a frame is handed over or searched
    ready_off_in_handshake: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (req_i || ack_i) |-> !s_ready_i)
        else begin
            $error("s_ready_o high while req or ack is high");
            fail_count++;
        end

endmodule

bind sss_detector_top sss_detector_props sss_detector_props_inst (
    .clk_i        (clk_i),
    .reset_ni     (reset_ni),
    .req_i        (frame_if.req),
    .ack_i        (frame_if.ack),
    .s_ready_i    (s_ready_o),
    .n_id_valid_i (n_id_valid_o),
    .n_id_1_i     (n_id_1_o)
);

`default_nettype wire

//--- bench/sss_detector_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "nr_sync_config.svh"

module sss_detector_tb import nr_cell_pkg::*, sss_corr_pkg::*;;

    localparam int RESULT_LIMIT = 43200;
    // seven frames, each well inside one result window
    localparam int CYCLE_LIMIT  = 7 * RESULT_LIMIT + 500;
    localparam int IDLE_CYCLES  = 140;

    logic    clk_i = 1'b0;
    logic    reset_ni;
    logic    s_data_i;
    logic    s_valid_i;
    logic    s_ready_o;
    n_id_2_t n_id_2_i;
    logic    n_id_2_valid_i;
    n_id_1_t n_id_1_o;
    n_id_t   n_id_o;
    logic    n_id_valid_o;

    integer  seed;
    int      cycle_count  = 0;
    int      value_errors = 0;
    int      other_errors = 0;
    int      results_seen = 0;

    // expected results in frame order
    string   exp_name_q[$];
    n_id_1_t exp_id1_q[$];
    n_id_t   exp_nid_q[$];
    string   cur_name;
    n_id_1_t cur_id1;
    n_id_t   cur_nid;

    sss_detector_top sss_detector_top_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .s_data_i       (s_data_i),
        .s_valid_i      (s_valid_i),
        .s_ready_o      (s_ready_o),
        .n_id_2_i       (n_id_2_i),
        .n_id_2_valid_i (n_id_2_valid_i),
        .n_id_1_o       (n_id_1_o),
        .n_id_o         (n_id_o),
        .n_id_valid_o   (n_id_valid_o)
    );

    always #20 clk_i = ~clk_i;

    // x0 and x1 from their recurrences, seed 1,0,0,0,0,0,0
    function automatic sss_word_t build_m_seq(input bit is_x1);
        sss_word_t x;
        x = '0;
        x[0] = 1'b1;
        for (int i = 0; i < `SSS_LEN - 7; i++) begin
            if (is_x1) begin
                x[i + 7] = x[i + 1] ^ x[i];
            end else begin
                x[i + 7] = x[i + 4] ^ x[i];
            end
        end
        return x;
    endfunction

    function automatic sss_word_t clean_sss(input int id1, input int id2);
        sss_word_t x0;
        sss_word_t x1;
        sss_word_t d;
        int        m0;
        int        m1;
        x0 = build_m_seq(1'b0);
        x1 = build_m_seq(1'b1);
        m0 = 15 * (id1 / `SHIFT_PERIOD) + 5 * id2;
        m1 = id1 % `SHIFT_PERIOD;
        for (int n = 0; n < `SSS_LEN; n++) begin
            d[n] = ~(x0[(n + m0) % `SSS_LEN] ^ x1[(n + m1) % `SSS_LEN]);
        end
        return d;
    endfunction

    // full search, first strict maximum of |agree - disagree| wins
    function automatic logic [18:0] reference_cell_id(input sss_word_t rx, input int id2);
        int best_mag;
        int best_id1;
        int score;
        best_mag = -1;
        best_id1 = 0;
        for (int id1 = 0; id1 <= `N_ID_1_MAX; id1++) begin
            score = `SSS_LEN - 2 * $countones(rx ^ clean_sss(id1, id2));
            if (score < 0) begin
                score = -score;
            end
            if (score > best_mag) begin
                best_mag = score;
                best_id1 = id1;
            end
        end
        return {n_id_1_t'(best_id1), n_id_t'(3 * best_id1 + id2)};
    endfunction

    function automatic sss_word_t flip_bits(input sss_word_t w, input int count);
        sss_word_t mask;
        int        pos;
        mask = '0;
        while ($countones(mask) < count) begin
            pos = {$random(seed)} % `SSS_LEN;
            mask[pos] = 1'b1;
        end
        return w ^ mask;
    endfunction

    task automatic show_error_counts();
        $display("summary: %0d value errors, %0d other errors, %0d assertion failures",
                 value_errors, other_errors,
                 sss_detector_top_inst.sss_detector_props_inst.fail_count);
    endtask

    // waits for the next result, optionally pushing junk on the stream meanwhile
    task automatic wait_result(input string name, input bit send_junk);
        int start_count;
        int waited;
        start_count = results_seen;
        waited = 0;
        while (results_seen == start_count && waited < RESULT_LIMIT) begin
            @(posedge clk_i);
            #2;
            waited++;
            s_valid_i = send_junk;
            s_data_i  = 1'($random(seed));
            if (results_seen == start_count) begin
                assert (!s_ready_o) else begin
                    $display("%s: s_ready_o went high before the result", name);
                    other_errors++;
                end
            end
        end
        s_valid_i = 1'b0;
        if (results_seen == start_count) begin
            $display("%s: no result within %0d cycles", name, RESULT_LIMIT);
            other_errors++;
        end
    endtask

    task automatic send_frame(input string name, input sss_word_t bits, input n_id_2_t id2,
                              input n_id_1_t exp_id1, input n_id_t exp_nid,
                              input bit junk_after);
        int waited;
        exp_name_q.push_back(name);
        exp_id1_q.push_back(exp_id1);
        exp_nid_q.push_back(exp_nid);
        waited = 0;
        while (!s_ready_o && waited < 100) begin
            @(posedge clk_i);
            #2;
            waited++;
        end
        if (!s_ready_o) begin
            $display("%s: s_ready_o never came back", name);
            other_errors++;
        end
        for (int n = 0; n < `SSS_LEN; n++) begin
            @(posedge clk_i);
            #2;
            s_valid_i      = 1'b1;
            s_data_i       = bits[n];
            n_id_2_i       = id2;
            n_id_2_valid_i = (n == 0);
        end
        wait_result(name, junk_after);
    endtask

    // compare process, samples at the falling edge where outputs are settled
    always @(negedge clk_i) begin
        if (reset_ni && n_id_valid_o) begin
            if (exp_name_q.size() == 0) begin
                $display("result pulse with no frame outstanding");
                other_errors++;
            end else begin
                cur_name = exp_name_q.pop_front();
                cur_id1  = exp_id1_q.pop_front();
                cur_nid  = exp_nid_q.pop_front();
                assert (n_id_1_o == cur_id1) else begin
                    $display("ERROR %s n_id_1: expected %0d actual %0d",
                             cur_name, cur_id1, n_id_1_o);
                    value_errors++;
                end
                assert (n_id_o == cur_nid) else begin
                    $display("ERROR %s n_id: expected %0d actual %0d",
                             cur_name, cur_nid, n_id_o);
                    value_errors++;
                end
            end
            results_seen++;
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, run did not complete", CYCLE_LIMIT);
            show_error_counts();
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        n_id_1_t     id1_a;
        n_id_1_t     id1_b;
        n_id_2_t     id2_v [0:4];
        sss_word_t   frame_a;
        sss_word_t   frame_b;
        logic [18:0] exp;
        seed           = 32'h4906_7d3d;
        reset_ni       = 1'b0;
        s_data_i       = 1'b0;
        s_valid_i      = 1'b0;
        n_id_2_i       = '0;
        n_id_2_valid_i = 1'b0;
        id1_a = n_id_1_t'({$random(seed)} % (`N_ID_1_MAX + 1));
        id1_b = n_id_1_t'({$random(seed)} % (`N_ID_1_MAX + 1));
        for (int i = 0; i < 5; i++) begin
            id2_v[i] = n_id_2_t'({$random(seed)} % 3);
        end
        repeat (4) @(posedge clk_i);
        #2;
        reset_ni = 1'b1;

        // idle: ready high, no result, while the m-sequences load
        repeat (IDLE_CYCLES) begin
            @(posedge clk_i);
            #2;
            assert (s_ready_o === 1'b1 && n_id_valid_o === 1'b0) else begin
                $display("idle: s_ready_o low or spurious n_id_valid_o after reset");
                other_errors++;
            end
        end

        // junk on the stream during the first search
        send_frame("clean_id1_0", clean_sss(0, id2_v[0]), id2_v[0],
                   9'd0, n_id_t'(id2_v[0]), 1'b1);
        send_frame("clean_id1_335", clean_sss(335, id2_v[1]), id2_v[1],
                   9'd335, n_id_t'(3 * 335 + id2_v[1]), 1'b0);
        frame_a = clean_sss(id1_a, id2_v[2]);
        send_frame("clean_rand_a", frame_a, id2_v[2],
                   id1_a, n_id_t'(3 * id1_a + id2_v[2]), 1'b0);
        frame_b = clean_sss(id1_b, id2_v[3]);
        send_frame("clean_rand_b", frame_b, id2_v[3],
                   id1_b, n_id_t'(3 * id1_b + id2_v[3]), 1'b0);
        send_frame("inverted_a", ~frame_a, id2_v[2],
                   id1_a, n_id_t'(3 * id1_a + id2_v[2]), 1'b0);
        frame_b = flip_bits(frame_b, 15);
        exp = reference_cell_id(frame_b, id2_v[3]);
        send_frame("noisy_b", frame_b, id2_v[3], exp[18:10], exp[9:0], 1'b0);
        for (int n = 0; n < `SSS_LEN; n++) begin
            frame_a[n] = 1'($random(seed));
        end
        exp = reference_cell_id(frame_a, id2_v[4]);
        send_frame("noise", frame_a, id2_v[4], exp[18:10], exp[9:0], 1'b0);

        repeat (4) @(posedge clk_i);
        if (exp_name_q.size() != 0) begin
            $display("%0d frames ended without a result", exp_name_q.size());
            other_errors++;
        end
        show_error_counts();
        if (value_errors + other_errors +
            sss_detector_top_inst.sss_detector_props_inst.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/m_seq_lfsr.sv
`timescale 1ns/1ps
`default_nettype none

module m_seq_lfsr #(
    parameter int unsigned    N    = 7,
    parameter logic [N-1:0]   TAPS = 'h11
) (
    input  logic clk_i,
    input  logic reset_ni,
    output logic data_o,
    output logic valid_o
);

    // state_q[0] is the oldest sample, state_q[N-1] the newest
    logic [N-1:0] state_q;
    logic         feedback;

    // next sample is the parity of the tapped history
    assign feedback = ^(state_q & TAPS);
    assign data_o   = state_q[0];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            // seed x(0..N-1) = 1,0,...,0
            state_q <= N'(1);
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b1;
            // seed is held for the first valid cycle so sample 0 goes out
            if (valid_o) begin
                state_q <= {feedback, state_q[N-1:1]};
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/nr_cell_pkg.sv
`default_nettype none

package nr_cell_pkg;

    // group identity within a sector, 0 to 335
    typedef logic [8:0] n_id_1_t;

    // sector identity from the PSS stage, 0 to 2
    typedef logic [1:0] n_id_2_t;

    // physical cell identity, 3*N_id_1 + N_id_2, 0 to 1007
    typedef logic [9:0] n_id_t;

endpackage

`default_nettype wire

//--- hw/nr_sync_config.svh
`ifndef NR_SYNC_CONFIG_SVH
`define NR_SYNC_CONFIG_SVH

// length of the SSS and of both m-sequences
`define SSS_LEN 127

// group identity runs from 0 to this value
`define N_ID_1_MAX 335

// N_id_1 div/mod this value gives the m_0 and m_1 shift terms
`define SHIFT_PERIOD 112

`endif

//--- hw/sss_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "nr_sync_config.svh"

module sss_capture import nr_cell_pkg::*, sss_corr_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_ni,
    input  logic     s_data_i,
    input  logic     s_valid_i,
    output logic     s_ready_o,
    input  n_id_2_t  n_id_2_i,
    input  logic     n_id_2_valid_i,
    sss_frame_if.src frame_o
);

    localparam logic [1:0] CAP_COLLECT = 2'd0;
    localparam logic [1:0] CAP_REQ     = 2'd1;
    localparam logic [1:0] CAP_RELEASE = 2'd2;

    localparam seq_pos_t LAST_BIT = seq_pos_t'(`SSS_LEN - 1);

    logic [1:0] state_q;
    seq_pos_t   bit_cnt_q;
    sss_word_t  frame_q;
    n_id_2_t    n_id_2_q;
    n_id_2_t    n_id_2_cur;
    n_id_2_t    frame_n_id_2_q;
    logic       accept;
    logic       last_bit;

    // bits are only taken while collecting
    assign s_ready_o = (state_q == CAP_COLLECT);
    assign accept    = s_valid_i && s_ready_o;
    assign last_bit  = accept && (bit_cnt_q == LAST_BIT);

    // a sector value arriving with the last bit still counts for this frame
    assign n_id_2_cur = n_id_2_valid_i ? n_id_2_i : n_id_2_q;

    assign frame_o.frame  = frame_q;
    assign frame_o.n_id_2 = frame_n_id_2_q;
    assign frame_o.req    = (state_q == CAP_REQ);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q   <= CAP_COLLECT;
            bit_cnt_q <= '0;
            n_id_2_q  <= '0;
        end else begin
            n_id_2_q <= n_id_2_cur;
            case (state_q)
                CAP_COLLECT: begin
                    if (last_bit) begin
                        bit_cnt_q <= '0;
                        state_q   <= CAP_REQ;
                    end else if (accept) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
                // drop req once the correlator has taken the frame
                CAP_REQ: begin
                    if (frame_o.ack) begin
                        state_q <= CAP_RELEASE;
                    end
                end
                // stay off the stream until the search is over
                default: begin
                    if (!frame_o.ack) begin
                        state_q <= CAP_COLLECT;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            frame_q[bit_cnt_q] <= s_data_i;
        end
        if (last_bit) begin
            frame_n_id_2_q <= n_id_2_cur;
        end
    end

endmodule

`default_nettype wire

//--- hw/sss_corr_pkg.sv
`default_nettype none

`include "nr_sync_config.svh"

package sss_corr_pkg;

    // one full sequence, bit n holds sample n
    typedef logic [`SSS_LEN-1:0] sss_word_t;

    // index into a sequence
    // also wide enough to hold SSS_LEN itself
    typedef logic [$clog2(`SSS_LEN)-1:0] seq_pos_t;

    // running sum of +1 per agreement and -1 per disagreement
    typedef logic signed [7:0] corr_t;

    // absolute value of a correlation sum
    typedef logic [6:0] corr_mag_t;

endpackage

`default_nettype wire

//--- hw/sss_correlator.sv
`timescale 1ns/1ps
`default_nettype none

`include "nr_sync_config.svh"

module sss_correlator import nr_cell_pkg::*, sss_corr_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_ni,
    input  logic     x0_i,
    input  logic     x1_i,
    input  logic     seq_valid_i,
    sss_frame_if.dst frame_i,
    output n_id_1_t  n_id_1_o,
    output n_id_t    n_id_o,
    output logic     n_id_valid_o
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_SEARCH = 2'd1;
    localparam logic [1:0] ST_DONE   = 2'd2;

    // m_0 grows by 15 for each full period of m_1
    localparam seq_pos_t M0_STEP    = seq_pos_t'(15);
    localparam seq_pos_t LAST_POS   = seq_pos_t'(`SSS_LEN - 1);
    localparam seq_pos_t CMP_SLOT   = seq_pos_t'(`SSS_LEN);
    localparam seq_pos_t LAST_SHIFT = seq_pos_t'(`SHIFT_PERIOD - 1);
    localparam n_id_1_t  LAST_CAND  = n_id_1_t'(`N_ID_1_MAX);

    logic [1:0] state_q;
    logic       ack_q;

    // m-sequence storage, filled once after reset
    sss_word_t  m0_q;
    sss_word_t  m1_q;
    seq_pos_t   fill_pos_q;
    logic       seq_done_q;

    sss_word_t  sss_q;
    seq_pos_t   cnt_q;
    seq_pos_t   base0_q;
    seq_pos_t   base1_q;
    seq_pos_t   p0_q;
    seq_pos_t   p1_q;
    seq_pos_t   m0_init;
    corr_t      acc_q;
    corr_mag_t  acc_mag;
    n_id_1_t    cand_q;
    n_id_t      cand_nid_q;
    corr_mag_t  best_mag_q;
    n_id_1_t    best_id1_q;
    n_id_t      best_nid_q;

    logic       start;
    logic       cmp_slot;
    logic       agree;
    logic       is_better;

    assign frame_i.ack = ack_q;

    assign start    = (state_q == ST_IDLE) && frame_i.req && seq_done_q;
    assign cmp_slot = (state_q == ST_SEARCH) && (cnt_q == CMP_SLOT);

    // 5 * N_id_2 as shift plus add
    assign m0_init = seq_pos_t'({frame_i.n_id_2, 2'b00}) + seq_pos_t'(frame_i.n_id_2);

    // expected sample is NOT(x0 xor x1) at the shifted positions
    assign agree = (sss_q[cnt_q] == ~(m0_q[p0_q] ^ m1_q[p1_q]));

    assign acc_mag   = acc_q[7] ? corr_mag_t'(-acc_q) : corr_mag_t'(acc_q);
    // strict compare keeps the lowest N_id_1 on a tie
    assign is_better = (acc_mag > best_mag_q);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q      <= ST_IDLE;
            ack_q        <= 1'b0;
            n_id_valid_o <= 1'b0;
            n_id_1_o     <= '0;
            n_id_o       <= '0;
            fill_pos_q   <= '0;
            seq_done_q   <= 1'b0;
            cnt_q        <= '0;
            cand_q       <= '0;
        end else begin
            if (seq_valid_i && !seq_done_q) begin
                if (fill_pos_q == LAST_POS) begin
                    seq_done_q <= 1'b1;
                end else begin
                    fill_pos_q <= fill_pos_q + 1'b1;
                end
            end

            n_id_valid_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        ack_q   <= 1'b1;
                        cnt_q   <= '0;
                        cand_q  <= '0;
                        state_q <= ST_SEARCH;
                    end
                end
                ST_SEARCH: begin
                    if (cmp_slot) begin
                        cnt_q <= '0;
                        if (cand_q == LAST_CAND) begin
                            n_id_1_o     <= is_better ? cand_q : best_id1_q;
                            n_id_o       <= is_better ? cand_nid_q : best_nid_q;
                            n_id_valid_o <= 1'b1;
                            state_q      <= ST_DONE;
                        end else begin
                            cand_q <= cand_q + 1'b1;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                // release the frame after the pulse once req has gone
                default: begin
                    if (!frame_i.req) begin
                        ack_q   <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (seq_valid_i && !seq_done_q) begin
            m0_q[fill_pos_q] <= x0_i;
            m1_q[fill_pos_q] <= x1_i;
        end

        if (start) begin
            sss_q      <= frame_i.frame;
            base0_q    <= m0_init;
            base1_q    <= '0;
            p0_q       <= m0_init;
            p1_q       <= '0;
            acc_q      <= '0;
            cand_nid_q <= n_id_t'(frame_i.n_id_2);
            best_mag_q <= '0;
        end else if (cmp_slot) begin
            acc_q <= '0;
            if (is_better) begin
                best_mag_q <= acc_mag;
                best_id1_q <= cand_q;
                best_nid_q <= cand_nid_q;
            end
            // N_id follows N_id_1 in steps of 3
            cand_nid_q <= cand_nid_q + n_id_t'(3);
            if (base1_q == LAST_SHIFT) begin
                base0_q <= base0_q + M0_STEP;
                base1_q <= '0;
                p0_q    <= base0_q + M0_STEP;
                p1_q    <= '0;
            end else begin
                base1_q <= base1_q + 1'b1;
                p0_q    <= base0_q;
                p1_q    <= base1_q + 1'b1;
            end
        end else if (state_q == ST_SEARCH) begin
            acc_q <= agree ? acc_q + 8'sd1 : acc_q - 8'sd1;
            // cyclic shift with wrap at the sequence end
            p0_q  <= (p0_q == LAST_POS) ? '0 : p0_q + 1'b1;
            p1_q  <= (p1_q == LAST_POS) ? '0 : p1_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/sss_detector_top.sv
`timescale 1ns/1ps
`default_nettype none

module sss_detector_top import nr_cell_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_ni,
    input  logic    s_data_i,
    input  logic    s_valid_i,
    output logic    s_ready_o,
    input  n_id_2_t n_id_2_i,
    input  logic    n_id_2_valid_i,
    output n_id_1_t n_id_1_o,
    output n_id_t   n_id_o,
    output logic    n_id_valid_o
);

    localparam int unsigned LFSR_LEN = 7;
    // x0 feeds back taps 4 and 0, x1 taps 1 and 0
    localparam logic [LFSR_LEN-1:0] X0_TAPS = 7'h11;
    localparam logic [LFSR_LEN-1:0] X1_TAPS = 7'h03;

    logic x0_bit;
    logic x0_valid;
    logic x1_bit;
    logic x1_valid;

    sss_frame_if frame_if ();

    m_seq_lfsr #(
        .N    (LFSR_LEN),
        .TAPS (X0_TAPS)
    ) x0_lfsr_inst (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .data_o   (x0_bit),
        .valid_o  (x0_valid)
    );

    m_seq_lfsr #(
        .N    (LFSR_LEN),
        .TAPS (X1_TAPS)
    ) x1_lfsr_inst (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .data_o   (x1_bit),
        .valid_o  (x1_valid)
    );

    sss_capture sss_capture_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .s_data_i       (s_data_i),
        .s_valid_i      (s_valid_i),
        .s_ready_o      (s_ready_o),
        .n_id_2_i       (n_id_2_i),
        .n_id_2_valid_i (n_id_2_valid_i),
        .frame_o        (frame_if.src)
    );

    sss_correlator sss_correlator_inst (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .x0_i         (x0_bit),
        .x1_i         (x1_bit),
        .seq_valid_i  (x0_valid & x1_valid),
        .frame_i      (frame_if.dst),
        .n_id_1_o     (n_id_1_o),
        .n_id_o       (n_id_o),
        .n_id_valid_o (n_id_valid_o)
    );

endmodule

`default_nettype wire

//--- hw/sss_frame_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sss_frame_if import nr_cell_pkg::*, sss_corr_pkg::*; ();

    // captured SSS bits and the sector they were received with
    sss_word_t frame;
    n_id_2_t   n_id_2;

    // four-phase handshake
    // ack stays high for the whole search
    logic      req;
    logic      ack;

    modport src (
        output frame,
        output n_id_2,
        output req,
        input  ack
    );

    modport dst (
        input  frame,
        input  n_id_2,
        input  req,
        output ack
    );

endinterface

`default_nettype wire

//--- tb.f
+incdir+hw
hw/nr_cell_pkg.sv
hw/sss_corr_pkg.sv
hw/sss_frame_if.sv
hw/m_seq_lfsr.sv
hw/sss_capture.sv
hw/sss_correlator.sv
hw/sss_detector_top.sv
bench/sss_detector_props.sv
bench/sss_detector_tb.sv
